// ==== source/mac_pkg.sv ====
`default_nettype none

package mac_pkg;

	localparam int PREAMBLE_LEN = 7;
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE = 8'hD5;
	localparam int ADDR_LEN = 6;
	localparam int TYPE_LEN = 2;
	localparam int HDR_LEN = 14;
	localparam int MIN_PAYLOAD = 46;
	localparam int FCS_LEN = 4;
	localparam int IFG_LEN = 12;
	localparam int FIFO_DEPTH = 2048;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);
	localparam int CNT_W = 11;
	// reflected form of 0x04C11DB7
	localparam logic [31:0] CRC_POLY = 32'hEDB88320;
	localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B;
	localparam logic [47:0] BROADCAST = 48'hFFFF_FFFF_FFFF;

	typedef logic [CNT_W-1:0] cnt_t;

	typedef struct packed {
		logic [47:0] dst;
		logic [47:0] src;
		logic [15:0] ethertype;
	} mac_hdr_t;

	typedef struct packed {
		logic [47:0] sta_addr;
		logic [47:0] tx_dst;
		logic [15:0] tx_type;
	} mac_cfg_t;

	typedef enum logic [3:0] {
		FLD_IDLE,
		FLD_PRE,
		FLD_SFD,
		FLD_DST,
		FLD_SRC,
		FLD_TYPE,
		FLD_PAY,
		FLD_PAD,
		FLD_FCS
	} tx_field_t;

	// APB byte offsets
	localparam logic [7:0] REG_STA_LO = 8'h00;
	localparam logic [7:0] REG_STA_HI = 8'h04;
	localparam logic [7:0] REG_DST_LO = 8'h08;
	localparam logic [7:0] REG_DST_HI = 8'h0C;
	localparam logic [7:0] REG_TYPE = 8'h10;
	localparam logic [7:0] REG_CTRL = 8'h14;
	localparam logic [7:0] REG_STATUS = 8'h18;
	localparam logic [7:0] REG_RX_SRC_LO = 8'h1C;
	localparam logic [7:0] REG_RX_SRC_HI = 8'h20;
	localparam logic [7:0] REG_RX_TYPE = 8'h24;
	localparam logic [7:0] REG_RX_GOOD = 8'h28;
	localparam logic [7:0] REG_RX_BAD = 8'h2C;

endpackage

`default_nettype wire

// ==== source/mac_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// per-byte steering from tx_fsm to the transmit datapath
interface tx_ctrl_if;
	mac_pkg::tx_field_t field;
	mac_pkg::cnt_t      byte_idx;
	logic               crc_en;
	logic               crc_clear;
	logic               fifo_rd;
	logic               phy_v;

	modport fsm (output field, byte_idx, crc_en, crc_clear, fifo_rd, phy_v);
	modport dp  (input field, byte_idx, crc_en, crc_clear, fifo_rd, phy_v);
endinterface

// receive header and frame status
interface rx_stat_if;
	mac_pkg::mac_hdr_t hdr;
	logic              hdr_valid;
	logic              good;
	logic              bad;

	modport source (output hdr, hdr_valid, good, bad);
	modport sink   (input hdr, hdr_valid, good, bad);
endinterface

`default_nettype wire

// ==== source/crc32.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc32 (
	input  logic        clk,
	input  logic        fsm_rst,
	input  logic        clear,
	input  logic [7:0]  d,
	input  logic        v,
	output logic [31:0] crc,
	output logic        ok
);

	logic [31:0] crc_nxt;
	logic [31:0] crc_rev;

	// one byte, lsb first
	always_comb begin
		crc_nxt = crc;
		for (int i = 0; i < 8; i++) begin
			if (crc_nxt[0] ^ d[i]) begin
				crc_nxt = (crc_nxt >> 1) ^ mac_pkg::CRC_POLY;
			end else begin
				crc_nxt = crc_nxt >> 1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fsm_rst || clear) begin
			crc <= '1;
		end else if (v) begin
			crc <= crc_nxt;
		end
	end

	// residue constant is in normal bit order
	assign crc_rev = {<<{crc}};
	assign ok = (crc_rev == mac_pkg::CRC_RESIDUE);

endmodule

`default_nettype wire

// ==== source/byte_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_fifo (
	input  logic       clk,
	input  logic       fsm_rst,
	input  logic [7:0] wr_d,
	input  logic       wr_v,
	output logic       full,
	input  logic       rd,
	output logic [7:0] rd_d,
	output logic       empty
);

	logic [7:0] mem [mac_pkg::FIFO_DEPTH];
	logic [mac_pkg::FIFO_AW-1:0] wr_ptr;
	logic [mac_pkg::FIFO_AW-1:0] rd_ptr;
	logic [mac_pkg::FIFO_AW:0]   fill;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_v && !full;
	assign do_rd = rd && !empty;
	assign full = (fill == (mac_pkg::FIFO_AW+1)'(mac_pkg::FIFO_DEPTH));
	assign empty = (fill == '0);

	always_ff @(posedge clk) begin
		if (fsm_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			fill <= fill + (mac_pkg::FIFO_AW+1)'(do_wr) - (mac_pkg::FIFO_AW+1)'(do_rd);
		end
	end

	// data follows rd by one cycle
	always_ff @(posedge clk) begin
		if (do_wr) mem[wr_ptr] <= wr_d;
		if (do_rd) rd_d <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

// ==== source/byte_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_counter #(
	parameter int WIDTH = mac_pkg::CNT_W
) (
	input  logic             clk,
	input  logic             fsm_rst,
	input  logic             clear,
	input  logic             en,
	output logic [WIDTH-1:0] count
);

	// clear wins over en
	always_ff @(posedge clk) begin
		if (fsm_rst) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (en) begin
			count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/tx_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_fsm (
	input  logic          clk,
	input  logic          fsm_rst,
	input  logic          start,
	output logic          busy,
	input  logic          fifo_empty,
	input  mac_pkg::cnt_t count,
	output logic          cnt_clear,
	output logic          cnt_en,
	tx_ctrl_if.fsm        ctrl
);

	typedef enum logic [3:0] {
		S_IDLE, S_PRE, S_SFD, S_DST, S_SRC, S_TYPE, S_PAY, S_PAD, S_FCS, S_GAP
	} state_t;

	state_t state;
	state_t state_nxt;
	logic   last_type;

	assign last_type = (count == mac_pkg::cnt_t'(mac_pkg::TYPE_LEN - 1));

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: if (start) state_nxt = S_PRE;
			S_PRE: if (count == mac_pkg::cnt_t'(mac_pkg::PREAMBLE_LEN - 1)) state_nxt = S_SFD;
			S_SFD: state_nxt = S_DST;
			S_DST: if (count == mac_pkg::cnt_t'(mac_pkg::ADDR_LEN - 1)) state_nxt = S_SRC;
			S_SRC: if (count == mac_pkg::cnt_t'(mac_pkg::ADDR_LEN - 1)) state_nxt = S_TYPE;
			S_TYPE: if (last_type) state_nxt = fifo_empty ? S_PAD : S_PAY;
			S_PAY: begin
				// empty here means the byte on fifo_d is the last one
				if (fifo_empty) begin
					if (count < mac_pkg::cnt_t'(mac_pkg::MIN_PAYLOAD - 1)) begin
						state_nxt = S_PAD;
					end else begin
						state_nxt = S_FCS;
					end
				end
			end
			S_PAD: if (count == mac_pkg::cnt_t'(mac_pkg::MIN_PAYLOAD - 1)) state_nxt = S_FCS;
			S_FCS: if (count == mac_pkg::cnt_t'(mac_pkg::FCS_LEN - 1)) state_nxt = S_GAP;
			S_GAP: if (count == mac_pkg::cnt_t'(mac_pkg::IFG_LEN)) state_nxt = S_IDLE;
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (fsm_rst) begin
			state <= S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// pad keeps counting on from the payload length
	assign cnt_clear = (state == S_IDLE) ||
		((state_nxt != state) && !(state == S_PAY && state_nxt == S_PAD));
	assign cnt_en = (state != S_IDLE);
	assign busy = (state != S_IDLE);

	always_comb begin
		case (state)
			S_PRE: ctrl.field = mac_pkg::FLD_PRE;
			S_SFD: ctrl.field = mac_pkg::FLD_SFD;
			S_DST: ctrl.field = mac_pkg::FLD_DST;
			S_SRC: ctrl.field = mac_pkg::FLD_SRC;
			S_TYPE: ctrl.field = mac_pkg::FLD_TYPE;
			S_PAY: ctrl.field = mac_pkg::FLD_PAY;
			S_PAD: ctrl.field = mac_pkg::FLD_PAD;
			S_FCS: ctrl.field = mac_pkg::FLD_FCS;
			default: ctrl.field = mac_pkg::FLD_IDLE;
		endcase
	end

	assign ctrl.byte_idx = count;
	assign ctrl.crc_clear = (state == S_SFD);
	assign ctrl.crc_en = (state inside {S_DST, S_SRC, S_TYPE, S_PAY, S_PAD});
	// read one cycle ahead of the payload byte
	assign ctrl.fifo_rd = ((state == S_TYPE && last_type) || state == S_PAY) && !fifo_empty;
	assign ctrl.phy_v = (state inside {S_PRE, S_SFD, S_DST, S_SRC, S_TYPE, S_PAY, S_PAD, S_FCS});

endmodule

`default_nettype wire

// ==== source/tx_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_datapath (
	input  logic              clk,
	input  logic              fsm_rst,
	input  mac_pkg::mac_cfg_t cfg,
	tx_ctrl_if.dp             ctrl,
	input  logic [7:0]        fifo_d,
	output logic [7:0]        crc_d,
	output logic              crc_v,
	output logic              crc_clear,
	input  logic [31:0]       crc,
	output logic [7:0]        phy_tx_d,
	output logic              phy_tx_v
);

	logic [47:0] dst_sr;
	logic [47:0] src_sr;
	logic [15:0] type_sr;
	logic [31:0] fcs_sr;
	logic [31:0] fcs;
	logic [7:0]  tx_byte;
	logic        fcs_first;

	assign fcs = ~crc;
	assign fcs_first = (ctrl.byte_idx == '0);

	always_comb begin
		case (ctrl.field)
			mac_pkg::FLD_PRE: tx_byte = mac_pkg::PREAMBLE_BYTE;
			mac_pkg::FLD_SFD: tx_byte = mac_pkg::SFD_BYTE;
			mac_pkg::FLD_DST: tx_byte = dst_sr[47:40];
			mac_pkg::FLD_SRC: tx_byte = src_sr[47:40];
			mac_pkg::FLD_TYPE: tx_byte = type_sr[15:8];
			mac_pkg::FLD_PAY: tx_byte = fifo_d;
			mac_pkg::FLD_FCS: tx_byte = fcs_first ? fcs[7:0] : fcs_sr[7:0];
			default: tx_byte = 8'h00;
		endcase
	end

	// header goes out msb first, fcs lsb first
	always_ff @(posedge clk) begin
		case (ctrl.field)
			mac_pkg::FLD_SFD: begin
				dst_sr <= cfg.tx_dst;
				src_sr <= cfg.sta_addr;
				type_sr <= cfg.tx_type;
			end
			mac_pkg::FLD_DST: dst_sr <= dst_sr << 8;
			mac_pkg::FLD_SRC: src_sr <= src_sr << 8;
			mac_pkg::FLD_TYPE: type_sr <= type_sr << 8;
			mac_pkg::FLD_FCS: fcs_sr <= fcs_first ? {8'h00, fcs[31:8]} : fcs_sr >> 8;
			default: ;
		endcase
		phy_tx_d <= tx_byte;
	end

	always_ff @(posedge clk) begin
		if (fsm_rst) begin
			phy_tx_v <= 1'b0;
		end else begin
			phy_tx_v <= ctrl.phy_v;
		end
	end

	assign crc_d = tx_byte;
	assign crc_v = ctrl.crc_en;
	assign crc_clear = ctrl.crc_clear;

endmodule

`default_nettype wire

// ==== source/rx_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_parser (
	input  logic              clk,
	input  logic              fsm_rst,
	input  mac_pkg::mac_cfg_t cfg,
	input  logic [7:0]        phy_rx_d,
	input  logic              phy_rx_v,
	output logic [7:0]        rx_d,
	output logic              rx_v,
	output logic              rx_sof,
	output logic              rx_eof,
	output logic              rx_err,
	rx_stat_if.source         stat
);

	logic pre_seen;
	logic in_frame;
	logic accept;
	logic sfd_hit;
	logic rx_byte;
	logic crc_ok;
	logic emit;
	logic first_pay;
	mac_pkg::cnt_t cnt;
	// four entries hold back the FCS, the fifth is the byte about to leave
	logic [4:0][7:0] dly;
	logic [111:0] hdr_sr;

	assign sfd_hit = !in_frame && pre_seen && phy_rx_v && (phy_rx_d == mac_pkg::SFD_BYTE);
	assign rx_byte = in_frame && phy_rx_v;
	assign first_pay = (cnt == mac_pkg::cnt_t'(mac_pkg::HDR_LEN + mac_pkg::FCS_LEN + 1));
	assign emit = in_frame && accept &&
		(cnt >= mac_pkg::cnt_t'(mac_pkg::HDR_LEN + mac_pkg::FCS_LEN + 1));
	assign stat.hdr = mac_pkg::mac_hdr_t'(hdr_sr);

	byte_counter rx_cnt (
		.clk     (clk),
		.fsm_rst (fsm_rst),
		.clear   (!in_frame),
		.en      (rx_byte),
		.count   (cnt)
	);

	crc32 rx_crc (
		.clk     (clk),
		.fsm_rst (fsm_rst),
		.clear   (!in_frame),
		.d       (phy_rx_d),
		.v       (rx_byte),
		.crc     (),
		.ok      (crc_ok)
	);

	always_ff @(posedge clk) begin
		if (fsm_rst) begin
			pre_seen <= 1'b0;
			in_frame <= 1'b0;
			accept <= 1'b0;
			rx_v <= 1'b0;
			rx_sof <= 1'b0;
			rx_eof <= 1'b0;
			rx_err <= 1'b0;
			stat.hdr_valid <= 1'b0;
			stat.good <= 1'b0;
			stat.bad <= 1'b0;
		end else begin
			pre_seen <= phy_rx_v && (phy_rx_d == mac_pkg::PREAMBLE_BYTE);
			if (sfd_hit) begin
				in_frame <= 1'b1;
			end else if (!phy_rx_v) begin
				in_frame <= 1'b0;
			end
			// destination is complete after six bytes
			if (sfd_hit) begin
				accept <= 1'b0;
			end else if (rx_byte && cnt == mac_pkg::cnt_t'(mac_pkg::ADDR_LEN)) begin
				accept <= (hdr_sr[47:0] == cfg.sta_addr) || (hdr_sr[47:0] == mac_pkg::BROADCAST);
			end
			stat.hdr_valid <= rx_byte && accept &&
				(cnt == mac_pkg::cnt_t'(mac_pkg::HDR_LEN - 1));
			// end of frame is seen when phy_rx_v drops
			rx_v <= emit;
			rx_sof <= emit && phy_rx_v && first_pay;
			rx_eof <= emit && !phy_rx_v;
			rx_err <= emit && !phy_rx_v && !crc_ok;
			stat.good <= emit && !phy_rx_v && crc_ok;
			stat.bad <= emit && !phy_rx_v && !crc_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (phy_rx_v) dly <= {dly[3:0], phy_rx_d};
		if (rx_byte && cnt < mac_pkg::cnt_t'(mac_pkg::HDR_LEN)) begin
			hdr_sr <= {hdr_sr[103:0], phy_rx_d};
		end
		if (emit) rx_d <= dly[4];
	end

endmodule

`default_nettype wire

// ==== source/apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_regs (
	input  logic              clk,
	input  logic              fsm_rst,
	input  logic [7:0]        paddr,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr,
	output mac_pkg::mac_cfg_t cfg,
	output logic              start,
	input  logic              busy,
	rx_stat_if.sink           stat
);

	logic        access;
	logic        mapped;
	logic        wr_en;
	logic        rx_hdr_seen;
	logic [47:0] rx_src;
	logic [15:0] rx_type;
	logic [31:0] rx_good;
	logic [31:0] rx_bad;

	assign access = psel && penable;
	assign wr_en = access && pwrite && mapped;
	assign pready = 1'b1;
	assign pslverr = access && !mapped;

	always_comb begin
		mapped = 1'b1;
		prdata = '0;
		case (paddr)
			mac_pkg::REG_STA_LO: prdata = cfg.sta_addr[31:0];
			mac_pkg::REG_STA_HI: prdata = {16'h0000, cfg.sta_addr[47:32]};
			mac_pkg::REG_DST_LO: prdata = cfg.tx_dst[31:0];
			mac_pkg::REG_DST_HI: prdata = {16'h0000, cfg.tx_dst[47:32]};
			mac_pkg::REG_TYPE: prdata = {16'h0000, cfg.tx_type};
			mac_pkg::REG_CTRL: prdata = {31'd0, start};
			mac_pkg::REG_STATUS: prdata = {30'd0, rx_hdr_seen, busy};
			mac_pkg::REG_RX_SRC_LO: prdata = rx_src[31:0];
			mac_pkg::REG_RX_SRC_HI: prdata = {16'h0000, rx_src[47:32]};
			mac_pkg::REG_RX_TYPE: prdata = {16'h0000, rx_type};
			mac_pkg::REG_RX_GOOD: prdata = rx_good;
			mac_pkg::REG_RX_BAD: prdata = rx_bad;
			default: mapped = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (fsm_rst) begin
			cfg <= '0;
			start <= 1'b0;
			rx_hdr_seen <= 1'b0;
			rx_good <= '0;
			rx_bad <= '0;
		end else begin
			// start clears itself after one cycle
			start <= wr_en && (paddr == mac_pkg::REG_CTRL) && pwdata[0];
			if (wr_en) begin
				case (paddr)
					mac_pkg::REG_STA_LO: cfg.sta_addr[31:0] <= pwdata;
					mac_pkg::REG_STA_HI: cfg.sta_addr[47:32] <= pwdata[15:0];
					mac_pkg::REG_DST_LO: cfg.tx_dst[31:0] <= pwdata;
					mac_pkg::REG_DST_HI: cfg.tx_dst[47:32] <= pwdata[15:0];
					mac_pkg::REG_TYPE: cfg.tx_type <= pwdata[15:0];
					default: ;
				endcase
			end
			if (stat.hdr_valid) rx_hdr_seen <= 1'b1;
			if (stat.good) rx_good <= rx_good + 1'b1;
			if (stat.bad) rx_bad <= rx_bad + 1'b1;
		end
	end

	// last accepted header
	always_ff @(posedge clk) begin
		if (stat.hdr_valid) begin
			rx_src <= stat.hdr.src;
			rx_type <= stat.hdr.ethertype;
		end
	end

endmodule

`default_nettype wire

// ==== source/mac_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_top (
	input  logic        clk,
	input  logic        fsm_rst,
	input  logic [7:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	input  logic [7:0]  tx_d,
	input  logic        tx_v,
	output logic        tx_full,
	output logic [7:0]  phy_tx_d,
	output logic        phy_tx_v,
	input  logic [7:0]  phy_rx_d,
	input  logic        phy_rx_v,
	output logic [7:0]  rx_d,
	output logic        rx_v,
	output logic        rx_sof,
	output logic        rx_eof,
	output logic        rx_err
);

	mac_pkg::mac_cfg_t cfg;
	mac_pkg::cnt_t     tx_count;
	logic        start;
	logic        busy;
	logic        cnt_clear;
	logic        cnt_en;
	logic        fifo_empty;
	logic [7:0]  fifo_d;
	logic [7:0]  crc_d;
	logic        crc_v;
	logic        crc_clear;
	logic [31:0] tx_crc_val;

	tx_ctrl_if tx_ctrl ();
	rx_stat_if rx_stat ();

	apb_regs u_regs (
		.clk (clk), .fsm_rst (fsm_rst),
		.paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
		.pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
		.cfg (cfg), .start (start), .busy (busy), .stat (rx_stat)
	);

	tx_fsm u_tx_fsm (
		.clk (clk), .fsm_rst (fsm_rst), .start (start), .busy (busy),
		.fifo_empty (fifo_empty), .count (tx_count),
		.cnt_clear (cnt_clear), .cnt_en (cnt_en), .ctrl (tx_ctrl)
	);

	byte_counter tx_cnt (
		.clk (clk), .fsm_rst (fsm_rst), .clear (cnt_clear), .en (cnt_en), .count (tx_count)
	);

	byte_fifo u_fifo (
		.clk (clk), .fsm_rst (fsm_rst), .wr_d (tx_d), .wr_v (tx_v), .full (tx_full),
		.rd (tx_ctrl.fifo_rd), .rd_d (fifo_d), .empty (fifo_empty)
	);

	tx_datapath u_tx_dp (
		.clk (clk), .fsm_rst (fsm_rst), .cfg (cfg), .ctrl (tx_ctrl), .fifo_d (fifo_d),
		.crc_d (crc_d), .crc_v (crc_v), .crc_clear (crc_clear), .crc (tx_crc_val),
		.phy_tx_d (phy_tx_d), .phy_tx_v (phy_tx_v)
	);

	crc32 tx_crc (
		.clk (clk), .fsm_rst (fsm_rst), .clear (crc_clear), .d (crc_d), .v (crc_v),
		.crc (tx_crc_val), .ok ()
	);

	rx_parser u_rx (
		.clk (clk), .fsm_rst (fsm_rst), .cfg (cfg),
		.phy_rx_d (phy_rx_d), .phy_rx_v (phy_rx_v),
		.rx_d (rx_d), .rx_v (rx_v), .rx_sof (rx_sof), .rx_eof (rx_eof), .rx_err (rx_err),
		.stat (rx_stat)
	);

endmodule

`default_nettype wire

// ==== sim/tb_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mac;

	typedef logic [7:0] byte_q_t [$];

	localparam logic [47:0] STA = 48'h02_11_22_33_44_55;
	localparam logic [47:0] OTHER = 48'h02_99_88_77_66_55;
	// looped frames are broadcast, so dst and src differ on the wire
	localparam logic [47:0] TX_DST = mac_pkg::BROADCAST;
	localparam logic [15:0] ETYPE = 16'h88B5;
	// frames of 86, 72, 72, 72 and 72 bytes
	localparam int FRAME_SUM = 86 + 72 + 72 + 72 + 72;
	localparam int CYCLE_LIMIT = 20 * FRAME_SUM + 2000;

	logic        clk;
	logic        fsm_rst;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic [7:0]  tx_d;
	logic        tx_v;
	logic        tx_full;
	logic [7:0]  phy_tx_d;
	logic        phy_tx_v;
	logic [7:0]  phy_rx_d;
	logic        phy_rx_v;
	logic [7:0]  rx_d;
	logic        rx_v;
	logic        rx_sof;
	logic        rx_eof;
	logic        rx_err;

	logic        inject;
	logic [7:0]  inj_d;
	logic        inj_v;

	int cyc;
	int errors;
	int tests_run;
	int tests_failed;
	int start_cyc;
	logic last_slverr;

	// transmit monitor state
	byte_q_t tx_got;
	logic    tx_prev;
	int      tx_run;
	int      tx_len;
	int      tx_rise_cyc;
	int      tx_frames;

	// receive monitor state
	byte_q_t rx_got;
	int      rx_v_count;
	int      rx_eofs;
	int      sof_pos;
	int      eof_pos;
	logic    eof_err;

	byte_q_t last_payload;

	// phy loopback unless the testbench injects its own frame
	assign phy_rx_d = inject ? inj_d : phy_tx_d;
	assign phy_rx_v = inject ? inj_v : phy_tx_v;

	mac_top uut (
		.clk (clk), .fsm_rst (fsm_rst),
		.paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
		.pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
		.tx_d (tx_d), .tx_v (tx_v), .tx_full (tx_full),
		.phy_tx_d (phy_tx_d), .phy_tx_v (phy_tx_v),
		.phy_rx_d (phy_rx_d), .phy_rx_v (phy_rx_v),
		.rx_d (rx_d), .rx_v (rx_v), .rx_sof (rx_sof), .rx_eof (rx_eof), .rx_err (rx_err)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc++;
		if (cyc >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	assert property (@(posedge clk) disable iff (fsm_rst) rx_err |-> rx_eof)
		else begin
			$display("rx_err was raised without rx_eof at %0t", $time);
			errors++;
		end

	assert property (@(posedge clk) disable iff (fsm_rst) rx_sof |-> rx_v)
		else begin
			$display("rx_sof was raised without rx_v at %0t", $time);
			errors++;
		end

	assert property (@(posedge clk) disable iff (fsm_rst) rx_eof |-> rx_v)
		else begin
			$display("rx_eof was raised without rx_v at %0t", $time);
			errors++;
		end

	assert property (@(posedge clk) disable iff (fsm_rst) (psel && penable) |-> pready)
		else begin
			$display("pready was low in an APB access cycle at %0t", $time);
			errors++;
		end

	always @(negedge clk) begin
		if (phy_tx_v) begin
			tx_got.push_back(phy_tx_d);
			if (!tx_prev) tx_rise_cyc = cyc;
			tx_run++;
		end else if (tx_prev) begin
			tx_len = tx_run;
			tx_run = 0;
			tx_frames++;
		end
		tx_prev = phy_tx_v;
		if (rx_v) begin
			if (rx_sof) sof_pos = rx_got.size();
			rx_got.push_back(rx_d);
			rx_v_count++;
		end
		if (rx_eof) begin
			eof_err = rx_err;
			eof_pos = rx_got.size();
			rx_eofs++;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(negedge clk);
		paddr = addr;
		pwrite = 1'b1;
		pwdata = data;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		#1;
		last_slverr = pslverr;
		@(negedge clk);
		start_cyc = cyc;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(negedge clk);
		paddr = addr;
		pwrite = 1'b0;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		#1;
		data = prdata;
		last_slverr = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			r = (r[0] ^ b[i]) ? ((r >> 1) ^ 32'hEDB88320) : (r >> 1);
		end
		return r;
	endfunction

	// full wire image from preamble to fcs
	task automatic build_frame(input logic [47:0] dst, input logic [47:0] src,
		input logic [15:0] etype, input byte_q_t pay, output byte_q_t q);
		logic [31:0] c;
		q = {};
		for (int i = 0; i < 7; i++) q.push_back(8'h55);
		q.push_back(8'hD5);
		for (int i = 5; i >= 0; i--) q.push_back(dst[i*8 +: 8]);
		for (int i = 5; i >= 0; i--) q.push_back(src[i*8 +: 8]);
		q.push_back(etype[15:8]);
		q.push_back(etype[7:0]);
		foreach (pay[i]) q.push_back(pay[i]);
		for (int i = pay.size(); i < 46; i++) q.push_back(8'h00);
		c = 32'hFFFF_FFFF;
		for (int i = 8; i < q.size(); i++) c = crc_byte(c, q[i]);
		c = ~c;
		for (int i = 0; i < 4; i++) q.push_back(c[i*8 +: 8]);
	endtask

	task automatic load_payload(input byte_q_t pay);
		foreach (pay[i]) begin
			@(negedge clk);
			while (tx_full) begin
				tx_v = 1'b0;
				@(negedge clk);
			end
			tx_d = pay[i];
			tx_v = 1'b1;
		end
		@(negedge clk);
		tx_v = 1'b0;
	endtask

	task automatic run_tx_frame(input int n, input bit check_busy);
		byte_q_t pay;
		byte_q_t exp;
		int frames0;
		int eofs0;
		logic [31:0] st;
		pay = {};
		for (int i = 0; i < n; i++) pay.push_back(8'($urandom));
		build_frame(TX_DST, STA, ETYPE, pay, exp);
		last_payload = pay;
		tx_got = {};
		rx_got = {};
		sof_pos = -1;
		frames0 = tx_frames;
		eofs0 = rx_eofs;
		load_payload(pay);
		apb_write(mac_pkg::REG_CTRL, 32'h1);
		if (check_busy) begin
			while (tx_run == 0) @(negedge clk);
			apb_read(mac_pkg::REG_STATUS, st);
			check_value("status busy during frame", {31'd0, st[0]}, 32'd1);
		end
		while (tx_frames == frames0) @(negedge clk);
		check_value("phy_tx_v rise delay", tx_rise_cyc - start_cyc, 32'd2);
		check_value("phy_tx_v length", tx_len, exp.size());
		check_value("phy_tx_d count", tx_got.size(), exp.size());
		for (int i = 0; i < exp.size() && i < tx_got.size(); i++) begin
			check_value($sformatf("phy_tx_d[%0d]", i), {24'd0, tx_got[i]}, {24'd0, exp[i]});
		end
		while (rx_eofs == eofs0) @(negedge clk);
	endtask

	task automatic inject_frame(input byte_q_t q);
		@(negedge clk);
		inject = 1'b1;
		foreach (q[i]) begin
			@(negedge clk);
			inj_v = 1'b1;
			inj_d = q[i];
		end
		@(negedge clk);
		inj_v = 1'b0;
		inj_d = 8'h00;
		repeat (16) @(negedge clk);
		inject = 1'b0;
	endtask

	task automatic check_rx_payload(input byte_q_t pay);
		check_value("rx_v byte count", rx_got.size(), 32'd46);
		check_value("rx_sof position", sof_pos, 32'd0);
		check_value("rx_eof position", eof_pos, 32'd46);
		for (int i = 0; i < 46 && i < rx_got.size(); i++) begin
			check_value($sformatf("rx_d[%0d]", i), {24'd0, rx_got[i]},
				(i < pay.size()) ? {24'd0, pay[i]} : 32'd0);
		end
	endtask

	task automatic end_test(input string name, input int err0);
		tests_run++;
		if (errors == err0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - err0);
		end
	endtask

	initial begin
		int err0;
		int eofs0;
		int rxv0;
		logic [31:0] rd;
		logic [31:0] good0;
		logic [31:0] bad0;
		byte_q_t pay;
		byte_q_t frm;

		void'($urandom(32'h5e912e47));
		fsm_rst = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		tx_d = '0;
		tx_v = 1'b0;
		inject = 1'b0;
		inj_d = '0;
		inj_v = 1'b0;
		tx_prev = 1'b0;
		sof_pos = -1;
		repeat (4) @(negedge clk);
		fsm_rst = 1'b0;

		// registers and reset state
		err0 = errors;
		check_value("phy_tx_v after reset", {31'd0, phy_tx_v}, 32'd0);
		check_value("rx_v after reset", {31'd0, rx_v}, 32'd0);
		check_value("tx_full after reset", {31'd0, tx_full}, 32'd0);
		apb_write(mac_pkg::REG_STA_LO, STA[31:0]);
		apb_write(mac_pkg::REG_STA_HI, {16'd0, STA[47:32]});
		apb_write(mac_pkg::REG_DST_LO, TX_DST[31:0]);
		apb_write(mac_pkg::REG_DST_HI, {16'd0, TX_DST[47:32]});
		apb_write(mac_pkg::REG_TYPE, {16'd0, ETYPE});
		apb_read(mac_pkg::REG_STA_LO, rd);
		check_value("REG_STA_LO", rd, STA[31:0]);
		apb_read(mac_pkg::REG_STA_HI, rd);
		check_value("REG_STA_HI", rd, {16'd0, STA[47:32]});
		apb_read(mac_pkg::REG_DST_LO, rd);
		check_value("REG_DST_LO", rd, TX_DST[31:0]);
		apb_read(mac_pkg::REG_DST_HI, rd);
		check_value("REG_DST_HI", rd, {16'd0, TX_DST[47:32]});
		apb_read(mac_pkg::REG_TYPE, rd);
		check_value("REG_TYPE", rd, {16'd0, ETYPE});
		apb_write(8'h40, 32'hDEAD_BEEF);
		check_value("pslverr on write 0x40", {31'd0, last_slverr}, 32'd1);
		apb_read(8'h40, rd);
		check_value("pslverr on read 0x40", {31'd0, last_slverr}, 32'd1);
		apb_read(mac_pkg::REG_STA_LO, rd);
		check_value("REG_STA_LO after bad write", rd, STA[31:0]);
		check_value("pslverr on mapped read", {31'd0, last_slverr}, 32'd0);
		end_test("registers", err0);

		err0 = errors;
		run_tx_frame(60, 1'b0);
		end_test("transmit frame", err0);

		// padded frame, then its loopback
		err0 = errors;
		apb_read(mac_pkg::REG_RX_GOOD, good0);
		run_tx_frame(10, 1'b1);
		repeat (20) @(negedge clk);
		apb_read(mac_pkg::REG_STATUS, rd);
		check_value("status busy after gap", {31'd0, rd[0]}, 32'd0);
		end_test("padding", err0);

		err0 = errors;
		check_rx_payload(last_payload);
		check_value("rx_err on loopback", {31'd0, eof_err}, 32'd0);
		apb_read(mac_pkg::REG_RX_SRC_LO, rd);
		check_value("REG_RX_SRC_LO", rd, STA[31:0]);
		apb_read(mac_pkg::REG_RX_SRC_HI, rd);
		check_value("REG_RX_SRC_HI", rd, {16'd0, STA[47:32]});
		apb_read(mac_pkg::REG_RX_TYPE, rd);
		check_value("REG_RX_TYPE", rd, {16'd0, ETYPE});
		apb_read(mac_pkg::REG_RX_GOOD, rd);
		check_value("REG_RX_GOOD", rd, good0 + 1);
		end_test("receive loopback", err0);

		// one payload bit flipped after the fcs is computed
		err0 = errors;
		pay = {};
		for (int i = 0; i < 46; i++) pay.push_back(8'($urandom));
		build_frame(STA, OTHER, ETYPE, pay, frm);
		frm[8 + 14 + 3] = frm[8 + 14 + 3] ^ 8'h10;
		apb_read(mac_pkg::REG_RX_BAD, bad0);
		eofs0 = rx_eofs;
		inject_frame(frm);
		check_value("rx_eof count", rx_eofs, eofs0 + 1);
		check_value("rx_err on flipped bit", {31'd0, eof_err}, 32'd1);
		apb_read(mac_pkg::REG_RX_BAD, rd);
		check_value("REG_RX_BAD", rd, bad0 + 1);
		end_test("crc error", err0);

		err0 = errors;
		apb_read(mac_pkg::REG_RX_GOOD, good0);
		apb_read(mac_pkg::REG_RX_BAD, bad0);
		build_frame(OTHER, OTHER, ETYPE, pay, frm);
		rxv0 = rx_v_count;
		inject_frame(frm);
		check_value("rx_v count for other unicast", rx_v_count, rxv0);
		apb_read(mac_pkg::REG_RX_GOOD, rd);
		check_value("REG_RX_GOOD after filter", rd, good0);
		apb_read(mac_pkg::REG_RX_BAD, rd);
		check_value("REG_RX_BAD after filter", rd, bad0);
		build_frame(mac_pkg::BROADCAST, OTHER, ETYPE, pay, frm);
		rx_got = {};
		sof_pos = -1;
		eofs0 = rx_eofs;
		inject_frame(frm);
		check_value("rx_eof count for broadcast", rx_eofs, eofs0 + 1);
		check_value("rx_err on broadcast", {31'd0, eof_err}, 32'd0);
		check_rx_payload(pay);
		apb_read(mac_pkg::REG_RX_GOOD, rd);
		check_value("REG_RX_GOOD after broadcast", rd, good0 + 1);
		end_test("address filter", err0);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
source/mac_pkg.sv
source/mac_if.sv
source/crc32.sv
source/byte_fifo.sv
source/byte_counter.sv
source/tx_fsm.sv
source/tx_datapath.sv
source/rx_parser.sv
source/apb_regs.sv
source/mac_top.sv
sim/tb_mac.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the Ethernet MAC testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_mac -f sim.f -o tb_mac_sim \
	&& ./obj_dir/tb_mac_sim > sim.log 2>&1
grep -q "TEST PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
